// File: logic/cu_pkg.sv
package cu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and fixed values
    ////////////////////////////////////////////////////////////////////////////

    localparam int INSTR_W    = 32;
    localparam int REG_ADDR_W = 4;
    localparam int ALU_FUNC_W = 5;

    // Return address register for CALL and RET
    localparam logic [REG_ADDR_W-1:0] LINK_REG = 4'd15;

    // Address add for load and store
    localparam logic [ALU_FUNC_W-1:0] ALU_FUNC_ADDR = 5'b10000;
    localparam logic [ALU_FUNC_W-1:0] ALU_FUNC_PASS = 5'b00000;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////////////////////

    localparam int MAJOR_HI = 31;
    localparam int MAJOR_LO = 28;
    localparam int MINOR_W  = 5;

    // Register fields, each REG_ADDR_W wide
    localparam int RS_HI = 27;
    localparam int RT_HI = 23;
    localparam int RD_HI = 19;

    ////////////////////////////////////////////////////////////////////////////
    // Decode keys, major opcode concatenated with minor opcode
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [8:0] {
        OP_ADD  = 9'b0000_00000,
        OP_SUB  = 9'b0000_00001,
        OP_SLT  = 9'b0000_00010,
        OP_SGT  = 9'b0000_00011,
        OP_AND  = 9'b0000_00100,
        OP_OR   = 9'b0000_00101,
        OP_XOR  = 9'b0000_00110,
        OP_NOT  = 9'b0000_00111,
        OP_LUI  = 9'b0000_01000,
        OP_SLL  = 9'b0000_01001,
        OP_SRL  = 9'b0000_01010,
        OP_SRA  = 9'b0000_01011,
        OP_NOR  = 9'b0000_01100,
        OP_INC  = 9'b0000_01101,
        OP_DEC  = 9'b0000_01110,
        OP_HAM  = 9'b0000_01111,
        OP_ADDI = 9'b0000_10000,
        OP_SUBI = 9'b0000_10001,
        OP_SLTI = 9'b0000_10010,
        OP_SGTI = 9'b0000_10011,
        OP_ANDI = 9'b0000_10100,
        OP_ORI  = 9'b0000_10101,
        OP_XORI = 9'b0000_10110,
        OP_NOTI = 9'b0000_10111,
        OP_SLLI = 9'b0000_11001,
        OP_SRLI = 9'b0000_11010,
        OP_SRAI = 9'b0000_11011,
        OP_MOVE = 9'b0000_11100,
        OP_CMOV = 9'b0000_11101,
        OP_LD   = 9'b0001_00000,
        OP_ST   = 9'b0010_00000,
        OP_BMI  = 9'b0011_00000,
        OP_BPL  = 9'b0100_00000,
        OP_BZ   = 9'b0101_00000,
        OP_RET  = 9'b1000_00000,
        OP_HALT = 9'b1001_00000,
        OP_NOP  = 9'b1010_00000
    } opcode_e;

    // Jumps decode on the major opcode alone
    typedef enum logic [3:0] {
        MAJ_BR   = 4'b0110,
        MAJ_CALL = 4'b0111
    } major_e;

    ////////////////////////////////////////////////////////////////////////////
    // Control encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        ACCESS_NONE  = 2'd0,
        ACCESS_LOAD  = 2'd1,
        ACCESS_STORE = 2'd2
    } access_e;

    typedef enum logic [2:0] {
        S_RESET  = 3'd0,
        S_FETCH1 = 3'd1,
        S_FETCH2 = 3'd2,
        S_EXEC   = 3'd3,
        S_MEM1   = 3'd4,
        S_MEM2   = 3'd5,
        S_MEM3   = 3'd6
    } seq_state_e;

    // Register write data source
    typedef enum logic [1:0] {
        WI_MEM  = 2'd0,
        WI_ALU  = 2'd1,
        WI_LINK = 2'd2
    } write_info_e;

    // Destination field choice
    typedef enum logic [1:0] {
        WR_RT   = 2'd0,
        WR_RD   = 2'd1,
        WR_LINK = 2'd2
    } write_reg_e;

endpackage

// File: logic/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder
(
    input  logic [cu_pkg::INSTR_W-1:0]    instruction,
    input  logic                          zero,
    input  logic                          sign,
    output logic [cu_pkg::REG_ADDR_W-1:0] source1,
    output logic [cu_pkg::REG_ADDR_W-1:0] source2,
    output logic [cu_pkg::REG_ADDR_W-1:0] destination,
    output logic [cu_pkg::ALU_FUNC_W-1:0] alu_func,
    output logic                          mem_read,
    output logic                          reg_read,
    output logic                          reg_write,
    output logic                          imm_sel,
    output cu_pkg::write_info_e           write_info_sel,
    output logic                          alu_in2,
    output cu_pkg::write_reg_e            write_reg_sel,
    output logic                          branch_op,
    output logic                          jump_addr_sel,
    output logic                          pc_in,
    output logic                          pc_sel,
    output cu_pkg::access_e               access
);

    logic [cu_pkg::REG_ADDR_W-1:0] rs;
    logic [cu_pkg::REG_ADDR_W-1:0] rt;
    logic [cu_pkg::REG_ADDR_W-1:0] rd;
    logic [cu_pkg::MINOR_W-1:0]    minor;
    cu_pkg::opcode_e               op;
    cu_pkg::major_e                major;

    assign rs    = instruction[cu_pkg::RS_HI -: cu_pkg::REG_ADDR_W];
    assign rt    = instruction[cu_pkg::RT_HI -: cu_pkg::REG_ADDR_W];
    assign rd    = instruction[cu_pkg::RD_HI -: cu_pkg::REG_ADDR_W];
    assign minor = instruction[cu_pkg::MINOR_W-1:0];

    assign op    = cu_pkg::opcode_e'({instruction[cu_pkg::MAJOR_HI:cu_pkg::MAJOR_LO], minor});
    assign major = cu_pkg::major_e'(instruction[cu_pkg::MAJOR_HI:cu_pkg::MAJOR_LO]);

    always_comb
    begin
        source1        = '0;
        source2        = '0;
        destination    = '0;
        alu_func       = cu_pkg::ALU_FUNC_PASS;
        mem_read       = 1'b0;
        reg_read       = 1'b0;
        reg_write      = 1'b0;
        imm_sel        = 1'b0;
        write_info_sel = cu_pkg::WI_MEM;
        alu_in2        = 1'b0;
        write_reg_sel  = cu_pkg::WR_RT;
        branch_op      = 1'b0;
        jump_addr_sel  = 1'b0;
        pc_in          = 1'b1;
        pc_sel         = 1'b0;
        access         = cu_pkg::ACCESS_NONE;

        ////////////////////////////////////////////////////////////////////////
        // Full key decode
        ////////////////////////////////////////////////////////////////////////

        case (op)
            // Two-operand register ops
            cu_pkg::OP_ADD, cu_pkg::OP_SUB, cu_pkg::OP_SLT, cu_pkg::OP_SGT,
            cu_pkg::OP_AND, cu_pkg::OP_OR, cu_pkg::OP_XOR, cu_pkg::OP_SLL,
            cu_pkg::OP_SRL, cu_pkg::OP_SRA, cu_pkg::OP_NOR, cu_pkg::OP_CMOV:
            begin
                source1        = rs;
                source2        = rt;
                destination    = rd;
                alu_func       = minor;
                reg_read       = 1'b1;
                reg_write      = 1'b1;
                write_info_sel = cu_pkg::WI_ALU;
                write_reg_sel  = cu_pkg::WR_RD;
            end

            // Unary ops write back into rt
            cu_pkg::OP_NOT, cu_pkg::OP_INC, cu_pkg::OP_DEC, cu_pkg::OP_HAM:
            begin
                source1        = rs;
                source2        = rt;
                destination    = rt;
                alu_func       = minor;
                reg_read       = 1'b1;
                reg_write      = 1'b1;
                write_info_sel = cu_pkg::WI_ALU;
            end

            cu_pkg::OP_MOVE:
            begin
                source1        = rs;
                destination    = rt;
                reg_read       = 1'b1;
                reg_write      = 1'b1;
                write_info_sel = cu_pkg::WI_ALU;
            end

            cu_pkg::OP_ADDI, cu_pkg::OP_SUBI, cu_pkg::OP_SLTI, cu_pkg::OP_SGTI,
            cu_pkg::OP_ANDI, cu_pkg::OP_ORI, cu_pkg::OP_XORI, cu_pkg::OP_SLLI,
            cu_pkg::OP_SRLI, cu_pkg::OP_SRAI:
            begin
                source1        = rs;
                source2        = rt;
                destination    = rt;
                alu_func       = minor;
                imm_sel        = 1'b1;
                alu_in2        = 1'b1;
                reg_read       = 1'b1;
                reg_write      = 1'b1;
                write_info_sel = cu_pkg::WI_ALU;
            end

            // Only the immediate feeds the ALU and rs is the target
            cu_pkg::OP_NOTI, cu_pkg::OP_LUI:
            begin
                source1        = rs;
                source2        = rs;
                destination    = rs;
                alu_func       = minor;
                imm_sel        = 1'b1;
                alu_in2        = 1'b1;
                reg_write      = 1'b1;
                write_info_sel = cu_pkg::WI_ALU;
            end

            cu_pkg::OP_LD, cu_pkg::OP_ST:
            begin
                source1   = rs;
                source2   = rt;
                destination = rt;
                alu_func  = cu_pkg::ALU_FUNC_ADDR;
                imm_sel   = 1'b1;
                alu_in2   = 1'b1;
                reg_read  = 1'b1;
                if (op == cu_pkg::OP_LD)
                begin
                    mem_read  = 1'b1;
                    reg_write = 1'b1;
                    access    = cu_pkg::ACCESS_LOAD;
                end
                else
                begin
                    access    = cu_pkg::ACCESS_STORE;
                end
            end

            cu_pkg::OP_BMI, cu_pkg::OP_BPL, cu_pkg::OP_BZ:
            begin
                source1     = rs;
                destination = rt;
                reg_read    = 1'b1;
                imm_sel     = 1'b1;
                case (op)
                    cu_pkg::OP_BMI: branch_op = sign;
                    cu_pkg::OP_BPL: branch_op = !sign && !zero;
                    default:        branch_op = zero;
                endcase
            end

            // Return address comes from the link register
            cu_pkg::OP_RET:
            begin
                source1       = cu_pkg::LINK_REG;
                jump_addr_sel = 1'b1;
                pc_sel        = 1'b1;
                reg_read      = 1'b1;
            end

            cu_pkg::OP_HALT:
            begin
                pc_in = 1'b0;
            end

            default: ;
        endcase

        ////////////////////////////////////////////////////////////////////////
        // Jumps ignore the minor bits
        ////////////////////////////////////////////////////////////////////////

        case (major)
            cu_pkg::MAJ_BR:
            begin
                pc_sel = 1'b1;
            end

            cu_pkg::MAJ_CALL:
            begin
                destination    = cu_pkg::LINK_REG;
                pc_sel         = 1'b1;
                reg_write      = 1'b1;
                write_info_sel = cu_pkg::WI_LINK;
                write_reg_sel  = cu_pkg::WR_LINK;
            end

            default: ;
        endcase
    end

endmodule

// File: logic/cycle_sequencer.sv
`timescale 1ns/1ps

module cycle_sequencer
(
    input  logic            clk,
    input  logic            reset,
    input  cu_pkg::access_e access,
    output logic            wmfc,
    output logic            mem_write
);

    cu_pkg::seq_state_e state;
    cu_pkg::seq_state_e state_next;
    logic               wmfc_next;
    logic               mem_write_next;

    ////////////////////////////////////////////////////////////////////////////
    // Next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        state_next = cu_pkg::S_FETCH1;
        case (state)
            cu_pkg::S_RESET:  state_next = cu_pkg::S_FETCH1;
            cu_pkg::S_FETCH1: state_next = cu_pkg::S_FETCH2;
            cu_pkg::S_FETCH2: state_next = cu_pkg::S_EXEC;
            cu_pkg::S_EXEC:
            begin
                if (access != cu_pkg::ACCESS_NONE)
                    state_next = cu_pkg::S_MEM1;
            end
            // Store finishes here, load carries on
            cu_pkg::S_MEM1:
            begin
                if (access == cu_pkg::ACCESS_LOAD)
                    state_next = cu_pkg::S_MEM2;
            end
            cu_pkg::S_MEM2:
            begin
                if (access == cu_pkg::ACCESS_LOAD)
                    state_next = cu_pkg::S_MEM3;
            end
            default:          state_next = cu_pkg::S_FETCH1;
        endcase
    end

    // Strobes belong to the state being entered
    always_comb
    begin
        case (state_next)
            cu_pkg::S_EXEC: wmfc_next = (access == cu_pkg::ACCESS_NONE);
            cu_pkg::S_MEM1: wmfc_next = (access == cu_pkg::ACCESS_STORE);
            cu_pkg::S_MEM3: wmfc_next = 1'b1;
            default:        wmfc_next = 1'b0;
        endcase
        mem_write_next = (state_next == cu_pkg::S_MEM1) && (access == cu_pkg::ACCESS_STORE);
    end

    ////////////////////////////////////////////////////////////////////////////
    // State and strobe registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state     <= cu_pkg::S_RESET;
            wmfc      <= 1'b0;
            mem_write <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            wmfc      <= wmfc_next;
            mem_write <= mem_write_next;
        end
    end

endmodule

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic [cu_pkg::INSTR_W-1:0]    instruction,
    input  logic                          zero,
    input  logic                          sign,
    output logic                          wmfc,
    output logic [cu_pkg::REG_ADDR_W-1:0] source1,
    output logic [cu_pkg::REG_ADDR_W-1:0] source2,
    output logic [cu_pkg::REG_ADDR_W-1:0] destination,
    output logic [cu_pkg::ALU_FUNC_W-1:0] alu_func,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic                          reg_read,
    output logic                          reg_write,
    output logic                          imm_sel,
    output cu_pkg::write_info_e           write_info_sel,
    output logic                          alu_in2,
    output cu_pkg::write_reg_e            write_reg_sel,
    output logic                          branch_op,
    output logic                          jump_addr_sel,
    output logic                          pc_in,
    output logic                          pc_sel
);

    // Memory class of the current instruction
    cu_pkg::access_e access;

    instr_decoder i_instr_decoder
    (
        .instruction    (instruction),
        .zero           (zero),
        .sign           (sign),
        .source1        (source1),
        .source2        (source2),
        .destination    (destination),
        .alu_func       (alu_func),
        .mem_read       (mem_read),
        .reg_read       (reg_read),
        .reg_write      (reg_write),
        .imm_sel        (imm_sel),
        .write_info_sel (write_info_sel),
        .alu_in2        (alu_in2),
        .write_reg_sel  (write_reg_sel),
        .branch_op      (branch_op),
        .jump_addr_sel  (jump_addr_sel),
        .pc_in          (pc_in),
        .pc_sel         (pc_sel),
        .access         (access)
    );

    cycle_sequencer i_cycle_sequencer
    (
        .clk       (clk),
        .reset     (reset),
        .access    (access),
        .wmfc      (wmfc),
        .mem_write (mem_write)
    );

endmodule

// File: sim/control_unit_tb.sv
`timescale 1ns/1ps

module control_unit_tb;

    localparam int MAX_VECTORS = 64;

    logic                          clk;
    logic                          reset;
    logic [cu_pkg::INSTR_W-1:0]    instruction;
    logic                          zero;
    logic                          sign;
    logic                          wmfc;
    logic                          mem_write;
    logic [cu_pkg::REG_ADDR_W-1:0] source1;
    logic [cu_pkg::REG_ADDR_W-1:0] source2;
    logic [cu_pkg::REG_ADDR_W-1:0] destination;
    logic [cu_pkg::ALU_FUNC_W-1:0] alu_func;
    logic                          mem_read;
    logic                          reg_read;
    logic                          reg_write;
    logic                          imm_sel;
    cu_pkg::write_info_e           write_info_sel;
    logic                          alu_in2;
    cu_pkg::write_reg_e            write_reg_sel;
    logic                          branch_op;
    logic                          jump_addr_sel;
    logic                          pc_in;
    logic                          pc_sel;

    // Packed decoder outputs in the field order of the data file
    logic [35:0]                   ctrl_word;

    logic [31:0]     vec_instr [MAX_VECTORS];
    logic            vec_zero  [MAX_VECTORS];
    logic            vec_sign  [MAX_VECTORS];
    logic [35:0]     vec_ctrl  [MAX_VECTORS];
    logic [3:0]      vec_len   [MAX_VECTORS];
    logic [8*12-1:0] vec_name  [MAX_VECTORS];

    int num_vectors   = 0;
    int cycle_limit   = 0;
    int cycle_count   = 0;
    int decode_errors = 0;
    int timing_errors = 0;
    int setup_errors  = 0;

    assign ctrl_word = {source1, source2, destination, 3'b000, alu_func,
                        mem_read, reg_read, reg_write, imm_sel,
                        write_info_sel, write_reg_sel,
                        alu_in2, branch_op, jump_addr_sel, pc_in,
                        3'b000, pc_sel};

    control_unit i_control_unit (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog
    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit)
        begin
            $display("Timeout: the run took more than %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Vector file
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_vectors();
        int               fd;
        logic [8*120-1:0] line;
        fd = $fopen("sim/control_unit_testdata.txt", "r");
        assert (fd != 0)
        else
        begin
            setup_errors++;
            $display("Could not open the test data file");
        end
        // Comment and blank lines do not scan as six fields
        while (fd != 0 && !$feof(fd) && num_vectors < MAX_VECTORS)
        begin
            line = '0;
            if ($fgets(line, fd) != 0)
                if ($sscanf(line, "%h %h %h %h %h %s", vec_instr[num_vectors],
                            vec_zero[num_vectors], vec_sign[num_vectors],
                            vec_ctrl[num_vectors], vec_len[num_vectors],
                            vec_name[num_vectors]) == 6)
                    num_vectors++;
        end
        if (fd != 0)
            $fclose(fd);
        assert (num_vectors > 0)
        else
        begin
            setup_errors++;
            $display("The test data file holds no vectors");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One instruction cycle, from apply to wmfc
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_vector(input int idx, input logic first);
        int gap;
        assert (wmfc === 1'b0 && mem_write === 1'b0)
        else
        begin
            timing_errors++;
            $display("Strobe still high when %0s was applied", vec_name[idx]);
        end
        instruction = vec_instr[idx];
        zero        = vec_zero[idx];
        sign        = vec_sign[idx];
        gap         = 1;
        @(negedge clk);
        gap++;
        assert (ctrl_word === vec_ctrl[idx])
        else
        begin
            decode_errors++;
            $display("FAILED %0s: expected %09h, actual %09h, write_info_sel %s",
                     vec_name[idx], vec_ctrl[idx], ctrl_word, write_info_sel.name());
        end
        while (wmfc !== 1'b1)
        begin
            assert (mem_write === 1'b0 && mem_read === vec_ctrl[idx][15])
            else
            begin
                timing_errors++;
                $display("Memory strobe wrong before wmfc in %0s", vec_name[idx]);
            end
            @(negedge clk);
            gap++;
        end
        // First cycle after reset spends one extra state in S_RESET
        assert (gap == vec_len[idx] + first)
        else
        begin
            timing_errors++;
            $display("FAILED %0s: expected %0d cycles, actual %0d cycles",
                     vec_name[idx], vec_len[idx] + first, gap);
        end
        assert (mem_write === (vec_len[idx] == 4))
        else
        begin
            timing_errors++;
            $display("The mem_write pulse is %0s in %0s",
                     mem_write ? "extra" : "missing", vec_name[idx]);
        end
        // Instruction stays put until the wmfc pulse is over
        @(negedge clk);
    endtask

    initial
    begin
        reset       = 1'b1;
        instruction = '0;
        zero        = 1'b0;
        sign        = 1'b0;
        load_vectors();
        cycle_limit = 6 * num_vectors + 20;
        repeat (3)
        begin
            @(negedge clk);
            assert (wmfc === 1'b0 && mem_write === 1'b0)
            else
            begin
                timing_errors++;
                $display("Strobe high while reset was held");
            end
        end
        reset = 1'b0;
        for (int i = 0; i < num_vectors; i++)
            run_vector(i, i == 0);
        assert (wmfc === 1'b0 && mem_write === 1'b0)
        else
        begin
            timing_errors++;
            $display("Last wmfc pulse lasted longer than one cycle");
        end
        $display("Errors: decode %0d, timing %0d, setup %0d",
                 decode_errors, timing_errors, setup_errors);
        if (decode_errors + timing_errors + setup_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: sim/control_unit_testdata.txt
# instruction zero sign control_word cycles name
# control_word: src1 src2 dst alu(8) {mrd rrd rwr imm} {wi wr} {in2 br jas pcin} pcsel
01230000 0 0 123006510 3 add
01230001 0 0 123016510 3 sub
0123000C 0 0 1230C6510 3 nor
0123001D 0 0 1231D6510 3 cmov
01230007 0 0 122076410 3 not
0123000F 0 0 1220F6410 3 ham
0123001C 0 0 102006410 3 move
01230010 0 0 122107490 3 addi
0123001B 0 0 1221B7490 3 srai
01230017 0 0 111173490 3 noti
01230008 0 0 111083490 3 lui
11230000 0 0 12210F090 6 ld
21230000 0 0 122105090 4 st
31230000 0 0 102005010 3 bmi_z0s0
31230000 0 1 102005050 3 bmi_z0s1
31230000 1 0 102005010 3 bmi_z1s0
31230000 1 1 102005050 3 bmi_z1s1
41230000 0 0 102005050 3 bpl_z0s0
41230000 0 1 102005010 3 bpl_z0s1
41230000 1 0 102005010 3 bpl_z1s0
41230000 1 1 102005010 3 bpl_z1s1
51230000 0 0 102005010 3 bz_z0s0
51230000 0 1 102005010 3 bz_z0s1
51230000 1 0 102005050 3 bz_z1s0
51230000 1 1 102005050 3 bz_z1s1
6123001F 1 1 000000011 3 br
71230005 0 1 00F002A11 3 call
81230000 0 0 F00004031 3 ret
91230000 0 0 000000000 3 halt
A1230000 0 0 000000010 3 nop
F1230000 0 0 000000010 3 unknown
21230000 0 0 122105090 4 st_again
11230000 0 0 12210F090 6 ld_again

// File: sources.f
logic/cu_pkg.sv
logic/instr_decoder.sv
logic/cycle_sequencer.sv
logic/control_unit.sv
sim/control_unit_tb.sv

// File: Bender.yml
package:
  name: control_unit

sources:
  - logic/cu_pkg.sv
  - logic/instr_decoder.sv
  - logic/cycle_sequencer.sv
  - logic/control_unit.sv
  - target: simulation
    files:
      - sim/control_unit_tb.sv
